/* hdl/uart_pkg.sv */
// shared bus beats, response codes and subsystem constants
// offsets compare against the full address; no address aliasing
package uart_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} aw_beat_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;   // only strb[0] matters for tx data
	} w_beat_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} resp_e;

	localparam logic [ADDR_W-1:0] REG_TXDATA  = 32'h0;
	localparam logic [ADDR_W-1:0] REG_BAUDDIV = 32'h4;

	localparam int BAUD_DIV_W = 16;
	localparam logic [BAUD_DIV_W-1:0] BAUD_DIV_RST = 16'd16;
	localparam logic [BAUD_DIV_W-1:0] BAUD_DIV_MIN = 16'd4;   // smaller divisors get SLVERR

	localparam int FIFO_DEPTH = 8;
	localparam logic [3:0] LFSR_SEED = 4'b0001;

endpackage

/* hdl/resp_lfsr.sv */
// 4-bit fibonacci lfsr, x^4+x^3+1, never reaches zero
`timescale 1ns/1ps

module resp_lfsr (
	input  logic       clk,
	input  logic       rstn,
	input  logic       step_i,
	output logic [3:0] value_o
);
	import uart_pkg::*;

	logic [3:0] lfsr_q;

	assign value_o = lfsr_q;

	// advances per accepted write, not per cycle
	always_ff @(posedge clk) begin
		if (rstn)
			lfsr_q <= LFSR_SEED;
		else if (step_i)
			lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
	end

endmodule

/* hdl/tx_fifo.sv */
// byte fifo, push when full and pop when empty are dropped
// data_o is the head entry, valid only while not empty
`timescale 1ns/1ps

module tx_fifo (
	input  logic       clk,
	input  logic       rstn,
	input  logic       push_i,
	input  logic [7:0] data_i,
	input  logic       pop_i,
	output logic [7:0] data_o,
	output logic       full_o,
	output logic       empty_o
);
	import uart_pkg::*;

	logic [7:0]                    mem_q [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(FIFO_DEPTH):0]   count_q;
	logic                          do_push;
	logic                          do_pop;

	assign full_o  = (int'(count_q) == FIFO_DEPTH);
	assign empty_o = (count_q == '0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign data_o  = mem_q[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (do_push)
			mem_q[wr_ptr_q] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= (int'(wr_ptr_q) == FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (int'(rd_ptr_q) == FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;   // both or neither
			endcase
		end
	end

endmodule

/* hdl/uart_tx.sv */
// 8N1 serializer; bit period latched at frame start
// divisor changes mid-frame take effect on the next frame
`timescale 1ns/1ps

module uart_tx (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            empty_i,
	input  logic [7:0]                      data_i,
	output logic                            pop_o,
	input  logic [uart_pkg::BAUD_DIV_W-1:0] baud_div_i,
	output logic                            tx_o
);
	import uart_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_SHIFT
	} state_e;

	state_e                state_q;
	logic [9:0]            shift_q;      // stop, data[7:0], start
	logic [3:0]            bit_cnt_q;
	logic [BAUD_DIV_W-1:0] baud_cnt_q;
	logic [BAUD_DIV_W-1:0] period_q;
	logic                  bit_end;

	assign pop_o   = (state_q == ST_IDLE) && !empty_i;
	assign bit_end = (baud_cnt_q == period_q - 1'b1);
	assign tx_o    = shift_q[0];   // all ones between frames

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q    <= ST_IDLE;
			shift_q    <= '1;
			bit_cnt_q  <= '0;
			baud_cnt_q <= '0;
			period_q   <= BAUD_DIV_RST;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (pop_o) begin
						state_q    <= ST_SHIFT;
						shift_q    <= {1'b1, data_i, 1'b0};
						period_q   <= baud_div_i;
						bit_cnt_q  <= '0;
						baud_cnt_q <= '0;
					end
				end
				ST_SHIFT: begin
					if (bit_end) begin
						baud_cnt_q <= '0;
						shift_q    <= {1'b1, shift_q[9:1]};
						bit_cnt_q  <= bit_cnt_q + 4'd1;
						if (bit_cnt_q == 4'd9)
							state_q <= ST_IDLE;   // stop bit done
					end else begin
						baud_cnt_q <= baud_cnt_q + 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/uart_wr_slave.sv */
// one write outstanding at a time; response comes 1..15 cycles after accept
// divisor writes take data[15:0], upper data bits are ignored
`timescale 1ns/1ps

module uart_wr_slave (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           aw_valid_i,
	input  uart_pkg::aw_beat_t             aw_i,
	output logic                           aw_ready_o,
	input  logic                           w_valid_i,
	input  uart_pkg::w_beat_t              w_i,
	output logic                           w_ready_o,
	output logic                           b_valid_o,
	output uart_pkg::resp_e                b_resp_o,
	input  logic                           b_ready_i,
	input  logic [3:0]                     delay_i,
	output logic                           delay_step_o,
	input  logic                           fifo_full_i,
	output logic                           push_o,
	output logic [7:0]                     push_data_o,
	output logic [uart_pkg::BAUD_DIV_W-1:0] baud_div_o
);
	import uart_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_RESP
	} state_e;

	state_e                state_q;
	logic [3:0]            delay_q;   // sampled lfsr value
	logic [3:0]            cnt_q;
	resp_e                 resp_q;
	logic [BAUD_DIV_W-1:0] baud_div_q;
	logic                  accept;
	logic                  is_tx;
	logic                  is_div;
	logic                  div_ok;
	logic                  b_hs;

	// both channels accepted together, held off while the fifo is full
	assign aw_ready_o = (state_q == ST_IDLE) && !fifo_full_i;
	assign w_ready_o  = (state_q == ST_IDLE) && !fifo_full_i;
	assign accept     = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;

	// register decode
	assign is_tx  = (aw_i.addr == REG_TXDATA);
	assign is_div = (aw_i.addr == REG_BAUDDIV);
	assign div_ok = (w_i.data[BAUD_DIV_W-1:0] >= BAUD_DIV_MIN);

	assign push_o       = accept && is_tx && w_i.strb[0];
	assign push_data_o  = w_i.data[7:0];
	assign delay_step_o = accept;   // next write sees a fresh delay

	// counter parks at D, so valid holds until the handshake
	assign b_valid_o  = (state_q == ST_RESP) && (cnt_q == delay_q);
	assign b_resp_o   = resp_q;
	assign b_hs       = b_valid_o && b_ready_i;
	assign baud_div_o = baud_div_q;

	always_ff @(posedge clk) begin
		if (accept)
			delay_q <= delay_i;
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q    <= ST_IDLE;
			cnt_q      <= '0;
			resp_q     <= RESP_OKAY;
			baud_div_q <= BAUD_DIV_RST;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= ST_RESP;
						cnt_q   <= '0;
						resp_q  <= (is_tx || (is_div && div_ok)) ? RESP_OKAY : RESP_SLVERR;
						if (is_div && div_ok)
							baud_div_q <= w_i.data[BAUD_DIV_W-1:0];
					end
				end
				ST_RESP: begin
					if (b_hs)
						state_q <= ST_IDLE;   // readies come back next cycle
					else if (cnt_q != delay_q)
						cnt_q <= cnt_q + 4'd1;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/uart_top.sv */
// uart transmit subsystem on a simplified write bus
// write-only, no receiver, no interrupts
`timescale 1ns/1ps

module uart_top (
	input  logic               clk,
	input  logic               rstn,
	input  logic               aw_valid_i,
	input  uart_pkg::aw_beat_t aw_i,
	output logic               aw_ready_o,
	input  logic               w_valid_i,
	input  uart_pkg::w_beat_t  w_i,
	output logic               w_ready_o,
	output logic               b_valid_o,
	output uart_pkg::resp_e    b_resp_o,
	input  logic               b_ready_i,
	output logic               tx_o
);
	import uart_pkg::*;

	logic [3:0]            lfsr_q;
	logic                  step;
	logic                  full;
	logic                  push;
	logic [7:0]            push_data;
	logic [BAUD_DIV_W-1:0] baud_div;
	logic                  empty;
	logic [7:0]            rd_data;
	logic                  pop;

	uart_wr_slave slave_i (
		.clk          (clk),
		.rstn         (rstn),
		.aw_valid_i   (aw_valid_i),
		.aw_i         (aw_i),
		.aw_ready_o   (aw_ready_o),
		.w_valid_i    (w_valid_i),
		.w_i          (w_i),
		.w_ready_o    (w_ready_o),
		.b_valid_o    (b_valid_o),
		.b_resp_o     (b_resp_o),
		.b_ready_i    (b_ready_i),
		.delay_i      (lfsr_q),
		.delay_step_o (step),
		.fifo_full_i  (full),
		.push_o       (push),
		.push_data_o  (push_data),
		.baud_div_o   (baud_div)
	);

	resp_lfsr lfsr_i (
		.clk     (clk),
		.rstn    (rstn),
		.step_i  (step),
		.value_o (lfsr_q)
	);

	tx_fifo fifo_i (
		.clk     (clk),
		.rstn    (rstn),
		.push_i  (push),
		.data_i  (push_data),
		.pop_i   (pop),
		.data_o  (rd_data),
		.full_o  (full),
		.empty_o (empty)
	);

	uart_tx tx_i (
		.clk        (clk),
		.rstn       (rstn),
		.empty_i    (empty),
		.data_i     (rd_data),
		.pop_o      (pop),
		.baud_div_i (baud_div),
		.tx_o       (tx_o)
	);

endmodule

/* dv/tb_clk_gen.sv */
// free running 10 ns clock, reset held high for the first 5 cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rstn_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		rstn_o = 1'b1;   // active high
		repeat (5) @(posedge clk_o);
		#1 rstn_o = 1'b0;
	end

endmodule

/* dv/uart_wr_chk.sv */
// response channel and serial line properties, bound into uart_top
// the testbench watches fail_cnt to stop on a failed assertion
`timescale 1ns/1ps

module uart_wr_chk (
	input logic            clk,
	input logic            rstn,
	input logic            aw_ready_i,
	input logic            w_ready_i,
	input logic            b_valid_i,
	input uart_pkg::resp_e b_resp_i,
	input logic            b_ready_i,
	input logic            tx_i
);
	import uart_pkg::*;

	int fail_cnt = 0;

	// response held until the master takes it
	resp_hold: assert property (@(posedge clk) disable iff (rstn)
		b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
		else begin
			fail_cnt++;
			$error("b_valid_o or b_resp_o changed before b_ready_i");
		end

	ready_off: assert property (@(posedge clk) disable iff (rstn)
		b_valid_i |-> !aw_ready_i && !w_ready_i)
		else begin
			fail_cnt++;
			$error("bus readies high while a response is pending");
		end

	// line idles high from the first reset edge on
	line_idle: assert property (@(posedge clk) rstn |=> tx_i)
		else begin
			fail_cnt++;
			$error("tx_o low while reset is active");
		end

endmodule

/* dv/tb_uart.sv */
// random write traffic against a reference model and a tx line decoder
// divisor writes are only issued with the line drained, so each byte has a known period
`timescale 1ns/1ps

module tb_uart;
	import uart_pkg::*;

	localparam int TIMEOUT = 20000;   // cycles per wait loop
	localparam int N_RAND  = 60;

	logic                  clk;
	logic                  rstn;
	logic                  aw_valid;
	aw_beat_t              aw;
	logic                  aw_ready;
	logic                  w_valid;
	w_beat_t               w;
	logic                  w_ready;
	logic                  b_valid;
	resp_e                 b_resp;
	logic                  b_ready;
	logic                  tx;
	integer                seed;
	logic [7:0]            exp_bytes[$];
	logic [BAUD_DIV_W-1:0] exp_div[$];   // bit period of each queued byte
	logic [BAUD_DIV_W-1:0] cur_div;
	logic                  stall_seen;
	int                    n_bytes;

	tb_clk_gen clk_gen_i (.clk_o(clk), .rstn_o(rstn));

	uart_top dut_i (
		.clk(clk), .rstn(rstn),
		.aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
		.w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
		.b_valid_o(b_valid), .b_resp_o(b_resp), .b_ready_i(b_ready),
		.tx_o(tx)
	);

	bind uart_top uart_wr_chk chk_i (
		.clk(clk), .rstn(rstn), .aw_ready_i(aw_ready_o), .w_ready_i(w_ready_o),
		.b_valid_i(b_valid_o), .b_resp_i(b_resp_o), .b_ready_i(b_ready_i), .tx_i(tx_o)
	);

	function automatic int rand_upto(input int max);
		return $unsigned($random(seed)) % (max + 1);
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	// returns the expected response and queues the byte or takes the new divisor
	function automatic resp_e model_write(input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		if (addr == REG_TXDATA) begin
			if (strb[0]) begin
				exp_bytes.push_back(data[7:0]);
				exp_div.push_back(cur_div);
			end
			return RESP_OKAY;
		end
		if (addr == REG_BAUDDIV && data[BAUD_DIV_W-1:0] >= BAUD_DIV_MIN) begin
			cur_div = data[BAUD_DIV_W-1:0];
			return RESP_OKAY;
		end
		return RESP_SLVERR;
	endfunction

	// with fast set there is no valid gap and the caller holds b_ready high
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, input bit fast);
		resp_e exp_resp;
		int    n;
		repeat (fast ? 0 : rand_upto(5)) @(posedge clk);
		@(posedge clk);
		#1;
		aw_valid = 1'b1;
		aw.addr  = addr;
		w_valid  = 1'b1;
		w.data   = data;
		w.strb   = strb;
		n = 0;
		@(negedge clk);
		while (!(aw_ready && w_ready)) begin
			n++;
			if (n > TIMEOUT)
				stop_run("write was never accepted");
			@(negedge clk);
		end
		@(posedge clk);   // accepted on this edge
		exp_resp = model_write(addr, data, strb);
		#1;
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!b_valid) begin
			n++;
			if (n > TIMEOUT)
				stop_run("no write response after an accepted write");
			@(negedge clk);
		end
		assert (b_resp == exp_resp) else
			stop_run($sformatf("FAIL t=%0t b_resp_o got %s exp %s", $time,
				b_resp.name(), exp_resp.name()));
		if (!fast) begin
			repeat (rand_upto(5)) @(posedge clk);
			@(posedge clk);
			#1 b_ready = 1'b1;
		end
		@(posedge clk);   // response handshake
		#1;
		if (!fast)
			b_ready = 1'b0;
		@(negedge clk);
		assert (!b_valid) else
			stop_run("second response seen for a single write");
		if (fast && !aw_ready)
			stall_seen = 1'b1;   // idle with readies low means fifo full
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_bytes.size() > 0) begin
			n++;
			if (n > TIMEOUT)
				stop_run("expected bytes never appeared on tx_o");
			@(negedge clk);
		end
	endtask

	// a bound assertion failure ends the run at once
	always @(negedge clk) begin
		if (dut_i.chk_i.fail_cnt != 0)
			stop_run("bound checker assertion failed");
	end

	// start is the first low negedge sample and each bit is sampled mid-period
	initial begin : line_decoder
		logic [7:0]            got;
		logic [BAUD_DIV_W-1:0] p;
		int                    idle;
		idle    = 0;
		n_bytes = 0;
		forever begin
			@(negedge clk);
			if (rstn || tx !== 1'b0) begin
				idle = (exp_bytes.size() > 0) ? idle + 1 : 0;
				if (idle > TIMEOUT)
					stop_run("no start bit while bytes are pending");
			end else begin
				assert (exp_bytes.size() > 0) else
					stop_run("frame on tx_o with no byte expected");
				p = exp_div[0];
				repeat (p / 2) @(negedge clk);
				assert (tx == 1'b0) else
					stop_run($sformatf("FAIL t=%0t tx_o start bit got %b exp 0", $time, tx));
				for (int i = 0; i < 8; i++) begin
					repeat (p) @(negedge clk);
					got[i] = tx;
				end
				repeat (p) @(negedge clk);
				assert (tx == 1'b1) else
					stop_run($sformatf("FAIL t=%0t tx_o stop bit got %b exp 1", $time, tx));
				assert (got == exp_bytes[0]) else
					stop_run($sformatf("FAIL t=%0t tx_o byte got %02h exp %02h", $time,
						got, exp_bytes[0]));
				void'(exp_bytes.pop_front());
				void'(exp_div.pop_front());
				n_bytes++;
				idle = 0;
			end
		end
	end

	initial begin : stimulus
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		int                kind;
		int                n;
		seed       = 20614;
		aw_valid   = 1'b0;
		aw         = '0;
		w_valid    = 1'b0;
		w          = '0;
		b_ready    = 1'b0;
		cur_div    = BAUD_DIV_RST;
		stall_seen = 1'b0;
		n = 0;
		@(negedge clk);
		while (rstn) begin
			n++;
			if (n > TIMEOUT)
				stop_run("reset never released");
			@(negedge clk);
		end
		assert (tx === 1'b1) else
			stop_run($sformatf("FAIL t=%0t tx_o got %b exp 1", $time, tx));
		assert (b_valid === 1'b0) else
			stop_run($sformatf("FAIL t=%0t b_valid_o got %b exp 0", $time, b_valid));
		assert (aw_ready === 1'b1 && w_ready === 1'b1) else
			stop_run($sformatf("FAIL t=%0t aw_ready_o/w_ready_o got %b%b exp 11", $time,
				aw_ready, w_ready));

		for (int i = 0; i < N_RAND; i++) begin
			kind = rand_upto(9);
			data = $random(seed);
			if (kind < 6) begin
				bus_write(REG_TXDATA, data, 4'($random(seed)), 1'b0);
			end else if (kind < 8) begin
				wait_drain();
				data = (rand_upto(2) == 0) ? rand_upto(3) : rand_upto(8) + 4;
				bus_write(REG_BAUDDIV, data, 4'hf, 1'b0);
			end else begin
				addr = $random(seed);
				if (addr == REG_TXDATA || addr == REG_BAUDDIV)
					addr = 32'h8;
				bus_write(addr, data, 4'hf, 1'b0);
			end
		end

		// slow line so the burst overruns the fifo
		wait_drain();
		bus_write(REG_BAUDDIV, 32'd40, 4'hf, 1'b0);
		@(posedge clk);
		#1 b_ready = 1'b1;
		for (int i = 0; i < FIFO_DEPTH + 4; i++)
			bus_write(REG_TXDATA, $random(seed), 4'h1, 1'b1);
		@(posedge clk);
		#1 b_ready = 1'b0;
		assert (stall_seen) else
			stop_run("readies never dropped while the fifo was full");
		wait_drain();
		repeat (5) @(negedge clk);

		if (dut_i.chk_i.fail_cnt == 0 && n_bytes > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("checker failures %0d, bytes decoded %0d", dut_i.chk_i.fail_cnt, n_bytes);
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* uart_sim.f */
hdl/uart_pkg.sv
hdl/resp_lfsr.sv
hdl/tx_fifo.sv
hdl/uart_tx.sv
hdl/uart_wr_slave.sv
hdl/uart_top.sv
dv/tb_clk_gen.sv
dv/uart_wr_chk.sv
dv/tb_uart.sv

/* Bender.yml */
package:
  name: uart_sim

sources:
  - hdl/uart_pkg.sv
  - hdl/resp_lfsr.sv
  - hdl/tx_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_wr_slave.sv
  - hdl/uart_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/uart_wr_chk.sv
      - dv/tb_uart.sv
